/* logic/soc_cfg.svh */
// SoC bus configuration
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Address bits 31:30 that select the I/O region, anything else is RAM
`define SOC_IO_REGION 2'b01

// Device bytes inside the I/O region
`define SOC_GPIO_ADDR 8'h40
`define SOC_UART_ADDR 8'h60
`define SOC_FLASH_ADDR 8'h70

// Fetch starts here after reset, inside the flash image
`define SOC_RESET_PC 32'h0010_0000

// Plain serial read opcode
`define SOC_FLASH_CMD_READ 8'h03

// ck cycles per UART bit and default RAM depth in words
`define SOC_BAUD_DIVIDE 278
`define SOC_RAM_WORDS 256

`endif

/* logic/soc_pkg.sv */
// SoC bus types
`default_nettype none

package soc_pkg;

    // Instruction bus, address is a byte address
    typedef struct packed {
        logic        cyc;
        logic [31:0] adr;
    } ibus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdt;
    } ibus_rsp_t;

    // One data address, seen as RAM word or as I/O device register
    typedef union packed {
        struct packed {
            logic [1:0]  region;
            logic [27:0] word;
            logic [1:0]  byte_ofs;
        } ram;
        struct packed {
            logic [1:0]  region;
            logic [13:0] rsvd;
            logic [7:0]  dev;
            logic [7:0]  reg_off;
        } io;
    } dbus_adr_u;

    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [3:0]  sel;
        dbus_adr_u   adr;
        logic [31:0] dat;
    } dbus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdt;
    } dbus_rsp_t;

endpackage

`default_nettype wire

/* logic/bus_arb.sv */
// Instruction bus priority arbiter
`timescale 1ns/1ps
`default_nettype none

module bus_arb (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire soc_pkg::ibus_req_t i_a_req,
    output soc_pkg::ibus_rsp_t      o_a_rsp,
    input  wire soc_pkg::ibus_req_t i_b_req,
    output soc_pkg::ibus_rsp_t      o_b_rsp,
    output soc_pkg::ibus_req_t      o_x_req,
    input  wire soc_pkg::ibus_rsp_t i_x_rsp
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_A    = 2'd1;
    localparam logic [1:0] ST_B    = 2'd2;

    logic [1:0] state;

    // Port a wins when both ask in the same idle cycle
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_a_req.cyc) begin
                        state <= ST_A;
                    end else if (i_b_req.cyc) begin
                        state <= ST_B;
                    end
                end
                default: begin
                    if (i_x_rsp.ack) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Owner gets the reader, the other side sees zero
    always_comb begin
        o_x_req = '0;
        o_a_rsp = '0;
        o_b_rsp = '0;
        case (state)
            ST_A: begin
                o_x_req = i_a_req;
                o_a_rsp = i_x_rsp;
            end
            ST_B: begin
                o_x_req = i_b_req;
                o_b_rsp = i_x_rsp;
            end
            default: ;
        endcase
    end

    assert property (@(posedge i_ck) disable iff (i_reset_loop)
        !(o_a_rsp.ack && o_b_rsp.ack))
        else $error("flash ack reached both masters");

    // Ownership only ends on the reader's ack
    assert property (@(posedge i_ck) disable iff (i_reset_loop)
        (state != ST_IDLE) && !i_x_rsp.ack |=> state == $past(state))
        else $error("arbiter grant changed without an ack");

endmodule

`default_nettype wire

/* logic/spi_flash_reader.sv */
// SPI flash word reader
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module spi_flash_reader (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire soc_pkg::ibus_req_t i_req,
    output soc_pkg::ibus_rsp_t      o_rsp,
    output logic                    o_sck,
    output logic                    o_ssb,
    output logic                    o_mosi,
    input  wire                     i_miso
);

    logic        active;
    // Counts sck half periods, 64 bits take 128
    logic [6:0]  half_cnt;
    logic [31:0] tx_shift;
    logic [31:0] rx_shift;
    logic        start;
    logic        last_half;
    logic        data_phase;

    // The cycle after an ack never restarts on the old request
    assign start      = !active && i_req.cyc && !o_rsp.ack;
    assign last_half  = active && (half_cnt == 7'd127);
    // Second half of the transfer, past opcode and address
    assign data_phase = half_cnt[6];

    assign o_mosi = tx_shift[31];

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            active   <= 1'b0;
            half_cnt <= '0;
            tx_shift <= '0;
            o_sck    <= 1'b0;
            o_ssb    <= 1'b1;
            o_rsp    <= '0;
        end else begin
            o_rsp <= '0;
            if (start) begin
                active   <= 1'b1;
                o_ssb    <= 1'b0;
                half_cnt <= '0;
                tx_shift <= {`SOC_FLASH_CMD_READ, i_req.adr[23:0]};
            end else if (active) begin
                half_cnt <= half_cnt + 7'd1;
                o_sck    <= ~o_sck;
                // Falling side moves the next bit out
                if (o_sck) begin
                    tx_shift <= {tx_shift[30:0], 1'b0};
                end
                if (last_half) begin
                    active    <= 1'b0;
                    o_ssb     <= 1'b1;
                    o_rsp.ack <= 1'b1;
                    // First byte on the wire is the lowest address
                    o_rsp.rdt <= {rx_shift[7:0], rx_shift[15:8],
                                  rx_shift[23:16], rx_shift[31:24]};
                end
            end
        end
    end

    // Sample on the rising side during the data bits
    always_ff @(posedge i_ck) begin
        if (active && !o_sck && data_phase) begin
            rx_shift <= {rx_shift[30:0], i_miso};
        end
    end

    assert property (@(posedge i_ck) disable iff (i_reset_loop)
        !active |-> o_ssb && !o_sck)
        else $error("flash select or clock active outside a transfer");

    // Select low to ack is one fixed transfer length
    assert property (@(posedge i_ck) disable iff (i_reset_loop)
        $fell(o_ssb) |-> ##128 o_rsp.ack)
        else $error("flash transfer did not end after 64 sck periods");

endmodule

`default_nettype wire

/* logic/flash_window.sv */
// Flash read window on the data bus
`timescale 1ns/1ps
`default_nettype none

module flash_window (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire                     i_sel,
    input  wire soc_pkg::dbus_req_t i_dbus,
    output soc_pkg::dbus_rsp_t      o_rsp,
    output soc_pkg::ibus_req_t      o_ibus_req,
    input  wire soc_pkg::ibus_rsp_t i_ibus_rsp
);

    logic [31:0] flash_adr;
    logic        rd_pend;
    logic        req_new;
    logic        is_adr_reg;
    logic        is_data_reg;

    // No new access while a flash read is out or the ack is up
    assign req_new     = i_sel && !rd_pend && !o_rsp.ack;
    assign is_adr_reg  = i_dbus.adr.io.reg_off == 8'h00;
    assign is_data_reg = i_dbus.adr.io.reg_off == 8'h04;

    assign o_ibus_req.cyc = rd_pend;
    assign o_ibus_req.adr = flash_adr;

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            rd_pend <= 1'b0;
            o_rsp   <= '0;
        end else begin
            o_rsp <= '0;
            if (rd_pend && i_ibus_rsp.ack) begin
                rd_pend   <= 1'b0;
                o_rsp.ack <= 1'b1;
                o_rsp.rdt <= i_ibus_rsp.rdt;
            end else if (req_new) begin
                if (!i_dbus.we && is_data_reg) begin
                    rd_pend <= 1'b1;
                end else begin
                    o_rsp.ack <= 1'b1;
                    if (!i_dbus.we && is_adr_reg) begin
                        o_rsp.rdt <= flash_adr;
                    end
                end
            end
        end
    end

    // Address register steps one word per completed read
    always_ff @(posedge i_ck) begin
        if (req_new && i_dbus.we && is_adr_reg) begin
            flash_adr <= i_dbus.dat;
        end else if (rd_pend && i_ibus_rsp.ack) begin
            flash_adr <= flash_adr + 32'd4;
        end
    end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
// UART transmitter, 8N1
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int BAUD_DIVIDE = 278
) (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire                     i_sel,
    input  wire soc_pkg::dbus_req_t i_dbus,
    output soc_pkg::dbus_rsp_t      o_rsp,
    output logic                    o_tx
);

    localparam int DIV_W = $clog2(BAUD_DIVIDE);

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    // Stop, data LSB first, start; shifts out from bit 0
    logic [9:0]       frame;
    logic             busy;
    logic             bit_end;
    logic             frame_end;
    logic             req_new;
    logic             wr_data;

    assign bit_end   = busy && (div_cnt == '0);
    assign frame_end = bit_end && (bit_cnt == 4'd9);
    assign req_new   = i_sel && !o_rsp.ack;
    assign wr_data   = req_new && i_dbus.we && (i_dbus.adr.io.reg_off == 8'h00);

    assign o_tx = frame[0];

    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
            frame   <= '1;
            o_rsp   <= '0;
        end else begin
            o_rsp <= '0;
            if (bit_end) begin
                frame   <= {1'b1, frame[9:1]};
                bit_cnt <= bit_cnt + 4'd1;
                div_cnt <= DIV_W'(BAUD_DIVIDE - 1);
                if (frame_end) begin
                    busy <= 1'b0;
                end
            end else if (busy) begin
                div_cnt <= div_cnt - 1'b1;
            end
            // Data write waits for the line, new frame starts with the ack
            if (wr_data && (!busy || frame_end)) begin
                frame     <= {1'b1, i_dbus.dat[7:0], 1'b0};
                busy      <= 1'b1;
                bit_cnt   <= '0;
                div_cnt   <= DIV_W'(BAUD_DIVIDE - 1);
                o_rsp.ack <= 1'b1;
            end else if (req_new && !wr_data) begin
                o_rsp.ack <= 1'b1;
                if (!i_dbus.we && (i_dbus.adr.io.reg_off == 8'h04)) begin
                    o_rsp.rdt <= {31'd0, busy};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/data_ram.sv */
// Data RAM with byte lanes
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire                     i_ck,
    input  wire                     i_sel,
    input  wire soc_pkg::dbus_req_t i_dbus,
    output soc_pkg::dbus_rsp_t      o_rsp
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // Upper word bits alias, the RAM wraps
    assign idx = i_dbus.adr.ram.word[IDX_W-1:0];

    // Ack settles to zero on the first clock with no select
    always_ff @(posedge i_ck) begin
        o_rsp.ack <= i_sel && !o_rsp.ack;
        if (i_sel && !i_dbus.we) begin
            o_rsp.rdt <= mem[idx];
        end else begin
            o_rsp.rdt <= '0;
        end
    end

    always_ff @(posedge i_ck) begin
        if (i_sel && i_dbus.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (i_dbus.sel[lane]) begin
                    mem[idx][8*lane +: 8] <= i_dbus.dat[8*lane +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/dbus_decode.sv */
// Data bus decoder and GPIO register
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module dbus_decode (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire soc_pkg::dbus_req_t i_dbus,
    output logic                    o_ram_sel,
    output logic                    o_uart_sel,
    output logic                    o_flash_sel,
    input  wire soc_pkg::dbus_rsp_t i_ram_rsp,
    input  wire soc_pkg::dbus_rsp_t i_uart_rsp,
    input  wire soc_pkg::dbus_rsp_t i_flash_rsp,
    output soc_pkg::dbus_rsp_t      o_dbus,
    output logic [7:0]              o_gpio
);

    logic               io_hit;
    logic               gpio_sel;
    logic [7:0]         gpio_q;
    soc_pkg::dbus_rsp_t gpio_rsp;

    assign io_hit = i_dbus.adr.io.region == `SOC_IO_REGION;

    // Select drops during the target's ack cycle
    assign o_ram_sel   = i_dbus.cyc && !io_hit && !i_ram_rsp.ack;
    assign o_uart_sel  = i_dbus.cyc && io_hit && (i_dbus.adr.io.dev == `SOC_UART_ADDR)
                         && !i_uart_rsp.ack;
    assign o_flash_sel = i_dbus.cyc && io_hit && (i_dbus.adr.io.dev == `SOC_FLASH_ADDR)
                         && !i_flash_rsp.ack;
    assign gpio_sel    = i_dbus.cyc && io_hit && (i_dbus.adr.io.dev == `SOC_GPIO_ADDR)
                         && !gpio_rsp.ack;

    // GPIO output byte, lane 0 only
    always_ff @(posedge i_ck) begin
        if (i_reset_loop) begin
            gpio_q   <= '0;
            gpio_rsp <= '0;
        end else begin
            gpio_rsp <= '0;
            if (gpio_sel) begin
                gpio_rsp.ack <= 1'b1;
                if (i_dbus.we) begin
                    if (i_dbus.sel[0]) begin
                        gpio_q <= i_dbus.dat[7:0];
                    end
                end else begin
                    gpio_rsp.rdt <= {24'd0, gpio_q};
                end
            end
        end
    end

    assign o_gpio = gpio_q;

    // Idle targets hold zero, so OR is the mux
    assign o_dbus.ack = i_ram_rsp.ack | i_uart_rsp.ack | i_flash_rsp.ack | gpio_rsp.ack;
    assign o_dbus.rdt = i_ram_rsp.rdt | i_uart_rsp.rdt | i_flash_rsp.rdt | gpio_rsp.rdt;

    assert property (@(posedge i_ck) disable iff (i_reset_loop)
        $onehot0({o_ram_sel, o_uart_sel, o_flash_sel, gpio_sel}))
        else $error("more than one data target selected");

    // Targets answer on their own timing, still never two at once
    assert property (@(posedge i_ck) disable iff (i_reset_loop)
        $onehot0({i_ram_rsp.ack, i_uart_rsp.ack, i_flash_rsp.ack, gpio_rsp.ack}))
        else $error("more than one data target acked");

endmodule

`default_nettype wire

/* logic/soc_bus.sv */
// SoC bus fabric top level
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_bus #(
    parameter int BAUD_DIVIDE = `SOC_BAUD_DIVIDE,
    parameter int RAM_WORDS   = `SOC_RAM_WORDS
) (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire soc_pkg::ibus_req_t i_ibus,
    output soc_pkg::ibus_rsp_t      o_ibus,
    input  wire soc_pkg::dbus_req_t i_dbus,
    output soc_pkg::dbus_rsp_t      o_dbus,
    output logic                    o_flash_sck,
    output logic                    o_flash_ssb,
    output logic                    o_flash_mosi,
    input  wire                     i_flash_miso,
    output logic                    o_tx,
    output logic [7:0]              o_gpio
);

    // Flash window to arbiter, arbiter to reader
    soc_pkg::ibus_req_t win_req;
    soc_pkg::ibus_rsp_t win_rsp;
    soc_pkg::ibus_req_t spi_req;
    soc_pkg::ibus_rsp_t spi_rsp;

    logic               ram_sel;
    logic               uart_sel;
    logic               flash_sel;
    soc_pkg::dbus_rsp_t ram_rsp;
    soc_pkg::dbus_rsp_t uart_rsp;
    soc_pkg::dbus_rsp_t flash_rsp;

    // Fetch port has priority
    bus_arb ibus_arb (
        .i_ck(i_ck), .i_reset_loop(i_reset_loop),
        .i_a_req(i_ibus), .o_a_rsp(o_ibus),
        .i_b_req(win_req), .o_b_rsp(win_rsp),
        .o_x_req(spi_req), .i_x_rsp(spi_rsp)
    );

    spi_flash_reader flash_reader (
        .i_ck(i_ck), .i_reset_loop(i_reset_loop),
        .i_req(spi_req), .o_rsp(spi_rsp),
        .o_sck(o_flash_sck), .o_ssb(o_flash_ssb),
        .o_mosi(o_flash_mosi), .i_miso(i_flash_miso)
    );

    flash_window flash_win (
        .i_ck(i_ck), .i_reset_loop(i_reset_loop), .i_sel(flash_sel),
        .i_dbus(i_dbus), .o_rsp(flash_rsp),
        .o_ibus_req(win_req), .i_ibus_rsp(win_rsp)
    );

    uart_tx #(.BAUD_DIVIDE(BAUD_DIVIDE)) uart (
        .i_ck(i_ck), .i_reset_loop(i_reset_loop), .i_sel(uart_sel),
        .i_dbus(i_dbus), .o_rsp(uart_rsp), .o_tx(o_tx)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) ram (
        .i_ck(i_ck), .i_sel(ram_sel), .i_dbus(i_dbus), .o_rsp(ram_rsp)
    );

    dbus_decode decode (
        .i_ck(i_ck), .i_reset_loop(i_reset_loop), .i_dbus(i_dbus),
        .o_ram_sel(ram_sel), .o_uart_sel(uart_sel), .o_flash_sel(flash_sel),
        .i_ram_rsp(ram_rsp), .i_uart_rsp(uart_rsp), .i_flash_rsp(flash_rsp),
        .o_dbus(o_dbus), .o_gpio(o_gpio)
    );

endmodule

`default_nettype wire

/* verif/soc_checker.sv */
// SoC bus response checker
`timescale 1ns/1ps
`default_nettype none

module soc_checker #(
    parameter int BIT_CYCLES = 16
) (
    input  wire                     i_ck,
    input  wire                     i_reset_loop,
    input  wire soc_pkg::ibus_rsp_t i_ibus_rsp,
    input  wire soc_pkg::dbus_rsp_t i_dbus_rsp,
    input  wire [7:0]               i_gpio,
    input  wire                     i_tx,
    input  wire                     i_flash_ssb,
    input  wire                     i_flash_sck,
    output int                      o_errors,
    output int                      o_checks,
    output int                      o_unmatched,
    output int                      o_frames
);

    typedef struct packed {
        logic [31:0] rdt;
        logic        chk_gpio;
        logic [7:0]  gpio;
    } dbus_exp_t;

    logic [31:0] ibus_q [$];
    dbus_exp_t   dbus_q [$];
    logic [7:0]  uart_q [$];
    int          error_cnt = 0;
    int          check_cnt = 0;
    int          frame_cnt = 0;
    int          pending_cnt = 0;
    logic        reset_q = 1'b1;
    logic        in_frame = 1'b0;
    int          bit_pos;
    logic [7:0]  rx_byte;

    assign o_errors    = error_cnt;
    assign o_checks    = check_cnt;
    assign o_frames    = frame_cnt;
    assign o_unmatched = pending_cnt;

    // Expectations posted by the stimulus
    task post_ibus(input logic [31:0] rdt);
        ibus_q.push_back(rdt);
    endtask

    task post_dbus(input logic [31:0] rdt, input logic chk_gpio, input logic [7:0] gpio);
        dbus_q.push_back({rdt, chk_gpio, gpio});
    endtask

    task post_uart(input logic [7:0] data);
        uart_q.push_back(data);
    endtask

    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_reset_state;
        check_cnt++;
        if (!i_flash_ssb || i_flash_sck || !i_tx || i_gpio != 8'd0) begin
            report_error($sformatf("after reset ssb %b sck %b tx %b gpio %h",
                                   i_flash_ssb, i_flash_sck, i_tx, i_gpio));
        end
    endtask

    task automatic check_ibus;
        logic [31:0] expect_rdt;
        if (i_ibus_rsp.ack) begin
            if (ibus_q.size() == 0) begin
                report_error("fetch ack with no request");
            end else begin
                expect_rdt = ibus_q.pop_front();
                check_cnt++;
                if (i_ibus_rsp.rdt != expect_rdt) begin
                    report_error($sformatf("fetch rdt %h, expected %h",
                                           i_ibus_rsp.rdt, expect_rdt));
                end
            end
        end else if (i_ibus_rsp.rdt != '0) begin
            report_error("fetch rdt not zero outside an ack");
        end
    endtask

    task automatic check_dbus;
        dbus_exp_t expect_rsp;
        if (i_dbus_rsp.ack) begin
            if (dbus_q.size() == 0) begin
                report_error("data bus ack with no request");
            end else begin
                expect_rsp = dbus_q.pop_front();
                check_cnt++;
                if (i_dbus_rsp.rdt != expect_rsp.rdt) begin
                    report_error($sformatf("data bus rdt %h, expected %h",
                                           i_dbus_rsp.rdt, expect_rsp.rdt));
                end
                if (expect_rsp.chk_gpio && i_gpio != expect_rsp.gpio) begin
                    report_error($sformatf("gpio %h, expected %h", i_gpio, expect_rsp.gpio));
                end
            end
        end else if (i_dbus_rsp.rdt != '0) begin
            report_error("data bus rdt not zero outside an ack");
        end
    endtask

    // Samples each bit in its middle, counted from the first low cycle
    task automatic track_uart;
        int slot;
        if (!in_frame) begin
            if (i_tx === 1'b0) begin
                in_frame = 1'b1;
                bit_pos  = 0;
            end
        end else begin
            bit_pos++;
            if (bit_pos == BIT_CYCLES / 2 && i_tx) begin
                report_error("UART start bit too short");
                in_frame = 1'b0;
            end else if (bit_pos > BIT_CYCLES / 2 &&
                         (bit_pos - BIT_CYCLES / 2) % BIT_CYCLES == 0) begin
                slot = (bit_pos - BIT_CYCLES / 2) / BIT_CYCLES;
                if (slot <= 8) begin
                    rx_byte = {i_tx, rx_byte[7:1]};
                end else begin
                    in_frame = 1'b0;
                    frame_cnt++;
                    if (!i_tx) begin
                        report_error("UART stop bit low");
                    end
                    if (uart_q.size() == 0) begin
                        report_error($sformatf("UART frame %h with no write", rx_byte));
                    end else begin
                        check_cnt++;
                        if (rx_byte != uart_q[0]) begin
                            report_error($sformatf("UART byte %h, expected %h",
                                                   rx_byte, uart_q[0]));
                        end
                        void'(uart_q.pop_front());
                    end
                end
            end
        end
    endtask

    // Mid-cycle sampling, all DUT outputs are settled here
    always @(negedge i_ck) begin
        if (i_reset_loop) begin
            in_frame = 1'b0;
        end else begin
            if (reset_q) begin
                check_reset_state();
            end
            check_ibus();
            check_dbus();
            track_uart();
        end
        reset_q     = i_reset_loop;
        pending_cnt = ibus_q.size() + dbus_q.size() + uart_q.size();
    end

endmodule

`default_nettype wire

/* verif/tb_soc_bus.sv */
// SoC bus fabric testbench
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module tb_soc_bus;

    localparam int BIT_CYCLES = 16;
    localparam int RAM_WORDS  = 64;
    localparam int TIMEOUT    = 4000;

    localparam logic [31:0] GPIO_ADR  = {`SOC_IO_REGION, 14'd0, `SOC_GPIO_ADDR, 8'h00};
    localparam logic [31:0] UART_DATA = {`SOC_IO_REGION, 14'd0, `SOC_UART_ADDR, 8'h00};
    localparam logic [31:0] UART_STAT = {`SOC_IO_REGION, 14'd0, `SOC_UART_ADDR, 8'h04};
    localparam logic [31:0] WIN_ADR   = {`SOC_IO_REGION, 14'd0, `SOC_FLASH_ADDR, 8'h00};
    localparam logic [31:0] WIN_DATA  = {`SOC_IO_REGION, 14'd0, `SOC_FLASH_ADDR, 8'h04};

    logic               ck;
    logic               reset_loop;
    soc_pkg::ibus_req_t ibus_req;
    soc_pkg::ibus_rsp_t ibus_rsp;
    soc_pkg::dbus_req_t dbus_req;
    soc_pkg::dbus_rsp_t dbus_rsp;
    logic               flash_sck;
    logic               flash_ssb;
    logic               flash_mosi;
    logic               flash_miso;
    logic               tx;
    logic [7:0]         gpio;
    int                 errors;
    int                 checks;
    int                 unmatched;
    int                 frames;
    int                 model_errors = 0;
    logic [31:0]        ram_model [RAM_WORDS];

    // Flash model state
    logic               sck_q = 1'b0;
    int                 flash_bit = 0;
    logic [31:0]        cmd_adr;
    logic [7:0]         data_byte;

    soc_bus #(
        .BAUD_DIVIDE(BIT_CYCLES),
        .RAM_WORDS(RAM_WORDS)
    ) soc_bus_inst (
        .i_ck(ck),
        .i_reset_loop(reset_loop),
        .i_ibus(ibus_req),
        .o_ibus(ibus_rsp),
        .i_dbus(dbus_req),
        .o_dbus(dbus_rsp),
        .o_flash_sck(flash_sck),
        .o_flash_ssb(flash_ssb),
        .o_flash_mosi(flash_mosi),
        .i_flash_miso(flash_miso),
        .o_tx(tx),
        .o_gpio(gpio)
    );

    soc_checker #(.BIT_CYCLES(BIT_CYCLES)) checker_inst (
        .i_ck(ck),
        .i_reset_loop(reset_loop),
        .i_ibus_rsp(ibus_rsp),
        .i_dbus_rsp(dbus_rsp),
        .i_gpio(gpio),
        .i_tx(tx),
        .i_flash_ssb(flash_ssb),
        .i_flash_sck(flash_sck),
        .o_errors(errors),
        .o_checks(checks),
        .o_unmatched(unmatched),
        .o_frames(frames)
    );

    initial begin
        ck = 1'b0;
        forever #4 ck = ~ck;
    end

    // Flash contents as a function of the byte address
    function automatic logic [7:0] flash_byte(input logic [31:0] adr);
        logic [31:0] prod;
        prod = adr * 32'd7 + 32'h3c;
        return prod[7:0];
    endfunction

    // Little endian, lowest address in bits 7:0
    function automatic logic [31:0] flash_word(input logic [31:0] adr);
        return {flash_byte(adr + 32'd3), flash_byte(adr + 32'd2),
                flash_byte(adr + 32'd1), flash_byte(adr)};
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                                input logic [31:0] dat,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
                res[8*lane +: 8] = dat[8*lane +: 8];
            end
        end
        return res;
    endfunction

    // SPI pins seen just after the clock edge, shifts in on rising sck, drives on falling sck
    always @(posedge ck) begin
        #1;
        if (flash_ssb) begin
            flash_bit = 0;
        end else if (flash_sck && !sck_q && flash_bit < 32) begin
            cmd_adr = {cmd_adr[30:0], flash_mosi};
            flash_bit++;
            if (flash_bit == 32 && cmd_adr[31:24] != `SOC_FLASH_CMD_READ) begin
                model_errors++;
                $display("ERROR at %0t ns: flash model got opcode %h", $time, cmd_adr[31:24]);
            end
        end else if (!flash_sck && sck_q && flash_bit >= 32 && flash_bit < 64) begin
            data_byte  = flash_byte({8'd0, cmd_adr[23:0]} + (flash_bit - 32) / 8);
            flash_miso = data_byte[7 - (flash_bit % 8)];
            flash_bit++;
        end
        sck_q = flash_sck;
    end

    task automatic timeout_abort(input string what);
        $display("Timed out waiting for %s", what);
        $display("test failed");
        $finish;
    endtask

    task automatic dbus_access(input logic we, input logic [3:0] sel,
                               input logic [31:0] adr, input logic [31:0] dat);
        int n;
        @(posedge ck);
        #1;
        dbus_req.cyc = 1'b1;
        dbus_req.we  = we;
        dbus_req.sel = sel;
        dbus_req.adr = adr;
        dbus_req.dat = dat;
        n = 0;
        @(negedge ck);
        while (!dbus_rsp.ack && n < TIMEOUT) begin
            n++;
            @(negedge ck);
        end
        if (!dbus_rsp.ack) begin
            timeout_abort("a data bus ack");
        end
        @(posedge ck);
        #1;
        dbus_req.cyc = 1'b0;
    endtask

    task automatic dbus_write(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        checker_inst.post_dbus(32'd0, 1'b0, 8'd0);
        dbus_access(1'b1, sel, adr, dat);
    endtask

    task automatic dbus_read(input logic [31:0] adr, input logic [31:0] expect_rdt);
        checker_inst.post_dbus(expect_rdt, 1'b0, 8'd0);
        dbus_access(1'b0, 4'hf, adr, 32'd0);
    endtask

    task automatic fetch(input logic [31:0] adr);
        int n;
        checker_inst.post_ibus(flash_word(adr));
        @(posedge ck);
        #1;
        ibus_req.cyc = 1'b1;
        ibus_req.adr = adr;
        n = 0;
        @(negedge ck);
        while (!ibus_rsp.ack && n < TIMEOUT) begin
            n++;
            @(negedge ck);
        end
        if (!ibus_rsp.ack) begin
            timeout_abort("a fetch ack");
        end
        @(posedge ck);
        #1;
        ibus_req.cyc = 1'b0;
    endtask

    task automatic wait_frames(input int count);
        int n;
        n = 0;
        while (frames < count && n < TIMEOUT) begin
            n++;
            @(posedge ck);
        end
        if (frames < count) begin
            timeout_abort("UART frames");
        end
    endtask

    task automatic ram_test;
        logic [31:0] dat;
        logic [3:0]  sel;
        int          idx;
        int          i;
        // Full words first so no lane is left unknown
        for (i = 0; i < 16; i++) begin
            dat = $urandom;
            ram_model[i] = dat;
            dbus_write(32'(i) << 2, dat, 4'hf);
        end
        for (i = 0; i < 40; i++) begin
            idx = $urandom_range(15, 0);
            dat = $urandom;
            sel = $urandom;
            ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
            dbus_write(32'(idx) << 2, dat, sel);
        end
        for (i = 0; i < 16; i++) begin
            dbus_read(32'(i) << 2, ram_model[i]);
        end
    endtask

    task automatic gpio_test;
        logic [31:0] dat;
        int          i;
        for (i = 0; i < 3; i++) begin
            dat = $urandom;
            checker_inst.post_dbus(32'd0, 1'b1, dat[7:0]);
            dbus_access(1'b1, 4'hf, GPIO_ADR, dat);
            checker_inst.post_dbus({24'd0, dat[7:0]}, 1'b1, dat[7:0]);
            dbus_access(1'b0, 4'hf, GPIO_ADR, 32'd0);
        end
    endtask

    task automatic uart_test;
        logic [7:0] first;
        logic [7:0] second;
        first  = $urandom;
        second = $urandom;
        dbus_read(UART_STAT, 32'd0);
        checker_inst.post_uart(first);
        dbus_write(UART_DATA, {24'd0, first}, 4'h1);
        dbus_read(UART_STAT, 32'd1);
        // Held off until the first frame ends
        checker_inst.post_uart(second);
        dbus_write(UART_DATA, {24'd0, second}, 4'h1);
        wait_frames(2);
    endtask

    task automatic window_test;
        logic [31:0] base;
        int          i;
        int          j;
        base = `SOC_RESET_PC + ($urandom & 32'h0000_fffc);
        dbus_write(WIN_ADR, base, 4'hf);
        fork
            begin
                for (i = 0; i < 3; i++) begin
                    dbus_read(WIN_DATA, flash_word(base + 32'(4 * i)));
                end
            end
            begin
                for (j = 0; j < 4; j++) begin
                    fetch(`SOC_RESET_PC + ($urandom & 32'h000f_fffc));
                    repeat ($urandom_range(3, 0)) @(posedge ck);
                end
            end
        join
        dbus_read(WIN_ADR, base + 32'd12);
    endtask

    initial begin
        int i;
        void'($urandom(32'h7aa0_9e42));
        reset_loop = 1'b1;
        ibus_req   = '0;
        dbus_req   = '0;
        flash_miso = 1'b0;
        repeat (2) @(posedge ck);
        #1;
        reset_loop = 1'b0;
        // Idle bus, any ack here is flagged by the checker
        repeat (6) @(posedge ck);
        ram_test();
        gpio_test();
        uart_test();
        for (i = 0; i < 6; i++) begin
            fetch(`SOC_RESET_PC + ($urandom & 32'h000f_fffc));
        end
        window_test();
        repeat (8) @(posedge ck);
        $display("checks %0d, errors %0d, unmatched %0d, flash model errors %0d",
                 checks, errors, unmatched, model_errors);
        if (errors == 0 && unmatched == 0 && model_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/soc_pkg.sv
logic/bus_arb.sv
logic/spi_flash_reader.sv
logic/flash_window.sv
logic/uart_tx.sv
logic/data_ram.sv
logic/dbus_decode.sv
logic/soc_bus.sv
verif/soc_checker.sv
verif/tb_soc_bus.sv
